// ==== files.f ====
src/lenet_pkg.sv
src/window_decode.sv
src/window_execute.sv
src/window_result.sv
src/lenet_window_engine.sv
verif/lenet_window_properties.sv
verif/tb_lenet_window_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the window engine testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lenet_window_engine \
    -f files.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// ==== src/lenet_pkg.sv ====
package lenet_pkg;

    ////////////////////////////////////////////////////////////
    // fixed-point widths
    ////////////////////////////////////////////////////////////

    localparam int PIX_W  = 16;  // pixel, weight, bias and result word
    localparam int FRAC_W = 8;   // q8.8 fraction bits
    localparam int WIN_N  = 4;   // 2x2 window
    localparam int ACC_W  = 34;  // 32-bit product plus two growth bits

    // saturation limits of a q8.8 word
    localparam logic signed [PIX_W-1:0] SAT_MAX = 16'sh7FFF;
    localparam logic signed [PIX_W-1:0] SAT_MIN = 16'sh8000;

    typedef logic [PIX_W-1:0] word_t;

    typedef enum logic [1:0] {
        OP_CONV      = 2'd0,
        OP_CONV_RELU = 2'd1,
        OP_POOL_MAX  = 2'd2  // code 3 left unused
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////

    // command as it arrives at the engine
    typedef struct packed {
        opcode_e                op;
        word_t [WIN_N-1:0]      pix;
        word_t [WIN_N-1:0]      wgt;
        word_t                  bias;
    } window_cmd_t;

    // decode to execute
    typedef struct packed {
        logic                   is_pool;
        logic                   relu;
        opcode_e                op;
        word_t [WIN_N-1:0]      pix;
        word_t [WIN_N-1:0]      wgt;
        logic [ACC_W-1:0]       bias_acc;  // bias already at product scale
    } exec_ctl_t;

    // execute to result
    typedef struct packed {
        logic                   is_pool;
        logic                   relu;
        opcode_e                op;
        logic [ACC_W-1:0]       acc;       // mac sum or widened pool max
        logic [ACC_W-1:0]       bias_acc;
    } acc_t;

    // engine output word
    typedef struct packed {
        opcode_e                op;
        word_t                  value;
    } result_t;

endpackage

// ==== src/lenet_window_engine.sv ====
`timescale 1ns/1ps

module lenet_window_engine (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  lenet_pkg::window_cmd_t  in_cmd,

    output logic                    out_valid,
    input  logic                    out_ready,
    output lenet_pkg::result_t      out_data
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////

    logic                   dec_valid;
    lenet_pkg::exec_ctl_t   dec_ctl;
    logic                   exe_advance;  // execute can accept
    logic                   exe_valid;
    lenet_pkg::acc_t        exe_acc;
    logic                   res_advance;  // result can accept

    window_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_cmd     (in_cmd),
        .in_ready   (in_ready),
        .advance    (exe_advance),
        .dec_valid  (dec_valid),
        .dec_ctl    (dec_ctl)
    );

    window_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_ctl     (dec_ctl),
        .advance     (exe_advance),
        .res_advance (res_advance),
        .exe_valid   (exe_valid),
        .exe_acc     (exe_acc)
    );

    window_result u_result (
        .clk         (clk),
        .rst         (rst),
        .exe_valid   (exe_valid),
        .exe_acc     (exe_acc),
        .res_advance (res_advance),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

// ==== src/window_decode.sv ====
`timescale 1ns/1ps

module window_decode (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_valid,
    input  lenet_pkg::window_cmd_t  in_cmd,
    output logic                    in_ready,

    input  logic                    advance,   // execute can take our item

    output logic                    dec_valid,
    output lenet_pkg::exec_ctl_t    dec_ctl
);

    ////////////////////////////////////////////////////////////
    // stall rule
    ////////////////////////////////////////////////////////////

    logic load;

    // free slot or the held item leaves this cycle
    assign in_ready = !dec_valid || advance;
    assign load     = in_ready && in_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // opcode flags and bias alignment
    ////////////////////////////////////////////////////////////

    logic                           is_pool;
    logic                           relu;
    logic [lenet_pkg::ACC_W-1:0]    bias_acc;

    always_comb begin
        is_pool = 1'b0;
        relu    = 1'b0;
        case (in_cmd.op)
            lenet_pkg::OP_POOL_MAX:  is_pool = 1'b1;
            lenet_pkg::OP_CONV_RELU: relu    = 1'b1;
            default: ;  // plain convolution
        endcase
    end

    // q8.8 bias moved up to q16.16 so it lines up with the products
    assign bias_acc = {
        {(lenet_pkg::ACC_W - lenet_pkg::PIX_W - lenet_pkg::FRAC_W)
            {in_cmd.bias[lenet_pkg::PIX_W-1]}},
        in_cmd.bias,
        {lenet_pkg::FRAC_W{1'b0}}
    };

    // payload register
    always_ff @(posedge clk) begin
        if (load) begin
            dec_ctl.is_pool  <= is_pool;
            dec_ctl.relu     <= relu;
            dec_ctl.op       <= in_cmd.op;
            dec_ctl.pix      <= in_cmd.pix;
            dec_ctl.wgt      <= in_cmd.wgt;
            dec_ctl.bias_acc <= bias_acc;
        end
    end

endmodule

// ==== src/window_execute.sv ====
`timescale 1ns/1ps

module window_execute (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    dec_valid,
    input  lenet_pkg::exec_ctl_t    dec_ctl,
    output logic                    advance,      // back to decode

    input  logic                    res_advance,  // result stage moves on

    output logic                    exe_valid,
    output lenet_pkg::acc_t         exe_acc
);

    ////////////////////////////////////////////////////////////
    // multiply-accumulate over the window
    ////////////////////////////////////////////////////////////

    logic signed [2*lenet_pkg::PIX_W-1:0]   prod [lenet_pkg::WIN_N];
    logic signed [lenet_pkg::ACC_W-1:0]     mac_sum;

    always_comb begin
        mac_sum = '0;
        for (int i = 0; i < lenet_pkg::WIN_N; i++) begin
            prod[i] = $signed(dec_ctl.pix[i]) * $signed(dec_ctl.wgt[i]);  // q16.16
            mac_sum = mac_sum + prod[i];  // sign extends into acc width
        end
    end

    ////////////////////////////////////////////////////////////
    // 2x2 max-pool
    ////////////////////////////////////////////////////////////

    logic signed [lenet_pkg::PIX_W-1:0] pool_max;

    always_comb begin
        pool_max = $signed(dec_ctl.pix[0]);
        for (int i = 1; i < lenet_pkg::WIN_N; i++) begin
            if ($signed(dec_ctl.pix[i]) > pool_max) begin
                pool_max = $signed(dec_ctl.pix[i]);
            end
        end
    end

    // pool result widened so both paths share one acc field
    logic [lenet_pkg::ACC_W-1:0] acc_next;

    assign acc_next = dec_ctl.is_pool
        ? {{(lenet_pkg::ACC_W - lenet_pkg::PIX_W){pool_max[lenet_pkg::PIX_W-1]}}, pool_max}
        : mac_sum;

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    logic load;

    assign advance = !exe_valid || res_advance;
    assign load    = advance && dec_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (advance) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            exe_acc.is_pool  <= dec_ctl.is_pool;
            exe_acc.relu     <= dec_ctl.relu;
            exe_acc.op       <= dec_ctl.op;
            exe_acc.acc      <= acc_next;
            exe_acc.bias_acc <= dec_ctl.bias_acc;  // added in the result stage
        end
    end

endmodule

// ==== src/window_result.sv ====
`timescale 1ns/1ps

module window_result (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    exe_valid,
    input  lenet_pkg::acc_t         exe_acc,
    output logic                    res_advance,  // back to execute

    input  logic                    out_ready,
    output logic                    out_valid,
    output lenet_pkg::result_t      out_data
);

    ////////////////////////////////////////////////////////////
    // bias, truncation, saturation, relu
    ////////////////////////////////////////////////////////////

    logic signed [lenet_pkg::ACC_W-1:0] biased;
    logic signed [lenet_pkg::ACC_W-1:0] scaled;
    logic signed [lenet_pkg::PIX_W-1:0] sat_val;
    logic signed [lenet_pkg::PIX_W-1:0] conv_val;
    lenet_pkg::word_t                   next_val;

    // q16.16 sum fits the acc width without overflow
    assign biased = exe_acc.acc + exe_acc.bias_acc;

    // dropping the extra fraction bits rounds toward minus infinity
    assign scaled = biased >>> lenet_pkg::FRAC_W;

    always_comb begin
        if (scaled > lenet_pkg::SAT_MAX) begin
            sat_val = lenet_pkg::SAT_MAX;
        end else if (scaled < lenet_pkg::SAT_MIN) begin
            sat_val = lenet_pkg::SAT_MIN;
        end else begin
            sat_val = scaled[lenet_pkg::PIX_W-1:0];
        end
    end

    always_comb begin
        conv_val = sat_val;
        if (exe_acc.relu && sat_val[lenet_pkg::PIX_W-1]) begin
            conv_val = '0;  // relu clamps negatives
        end
    end

    // pool max already a q8.8 word in the low bits
    assign next_val = exe_acc.is_pool ? exe_acc.acc[lenet_pkg::PIX_W-1:0] : conv_val;

    ////////////////////////////////////////////////////////////
    // output handshake
    ////////////////////////////////////////////////////////////

    logic load;

    // output slot free or the consumer takes it now
    assign res_advance = !out_valid || out_ready;
    assign load        = res_advance && exe_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (res_advance) begin
            out_valid <= exe_valid;
        end
    end

    // data holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_data.op    <= exe_acc.op;
            out_data.value <= next_val;
        end
    end

endmodule

// ==== verif/lenet_window_properties.sv ====
`timescale 1ns/1ps

module lenet_window_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input lenet_pkg::result_t   out_data
);

    ////////////////////////////////////////////////////////////
    // output handshake
    ////////////////////////////////////////////////////////////

    // stalled result keeps valid and data
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid or out_data changed while the output was stalled");

    reset_clear: assert property (@(posedge clk)
        rst |=> !out_valid)  // pipe empty out of reset
        else $error("out_valid high in the cycle after reset");

    ////////////////////////////////////////////////////////////
    // input handshake
    ////////////////////////////////////////////////////////////

    // all stages empty once reset has been applied
    in_free: assert property (@(posedge clk)
        rst |=> in_ready)
        else $error("in_ready low in the cycle after reset");

endmodule

// ==== verif/tb_lenet_window_engine.sv ====
`timescale 1ns/1ps

module tb_lenet_window_engine;

    localparam int N_CONV      = 40;
    localparam int N_SAT       = 4;
    localparam int N_RELU      = 20;   // pairs of conv then conv_relu
    localparam int N_POOL      = 20;
    localparam int N_STREAM    = 200;
    localparam int TOTAL_CMDS  = 1 + N_CONV + N_SAT + 2 * N_RELU + N_POOL + N_STREAM;
    localparam int WATCHDOG_NS = (TOTAL_CMDS + 20) * 4 * 40;

    localparam longint Q_MAX = 32767;   // q8.8 word limits
    localparam longint Q_MIN = -32768;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    lenet_pkg::window_cmd_t in_cmd;
    logic                   out_valid;
    logic                   out_ready;
    lenet_pkg::result_t     out_data;

    integer                 seed;
    logic                   ready_random;  // random back-pressure on the output
    int                     pass_count;
    int                     fail_count;
    int                     test_fail_base;
    lenet_pkg::result_t     exp_q[$];
    lenet_pkg::result_t     exp_res;
    lenet_pkg::result_t     last_out;

    lenet_window_engine uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_cmd    (in_cmd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind lenet_window_engine lenet_window_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic lenet_pkg::result_t ref_window(input lenet_pkg::window_cmd_t cmd);
        lenet_pkg::result_t  r;
        longint              sum;
        longint              floored;
        logic signed [15:0]  best;
        r.op = cmd.op;
        if (cmd.op == lenet_pkg::OP_POOL_MAX) begin
            best = $signed(cmd.pix[0]);
            for (int i = 1; i < lenet_pkg::WIN_N; i++) begin
                if ($signed(cmd.pix[i]) > best) best = $signed(cmd.pix[i]);
            end
            r.value = best;
        end else begin
            sum = longint'($signed(cmd.bias)) <<< 8;  // bias at q16.16
            for (int i = 0; i < lenet_pkg::WIN_N; i++) begin
                sum = sum + longint'($signed(cmd.pix[i])) * longint'($signed(cmd.wgt[i]));
            end
            floored = sum >>> 8;
            if (floored > Q_MAX) r.value = 16'h7FFF;
            else if (floored < Q_MIN) r.value = 16'h8000;
            else r.value = floored[15:0];
            if (cmd.op == lenet_pkg::OP_CONV_RELU && r.value[15]) r.value = '0;
        end
        return r;
    endfunction

    function automatic lenet_pkg::word_t any_word();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // roughly +-4.0 in q8.8
    function automatic lenet_pkg::word_t small_word();
        int r;
        r = $random(seed);
        return {{5{r[10]}}, r[10:0]};
    endfunction

    function automatic lenet_pkg::word_t pos_word();
        int r;
        r = $random(seed);
        return {6'b0, r[9:0]};
    endfunction

    function automatic lenet_pkg::word_t neg_word();
        return ~pos_word();  // always below zero
    endfunction

    function automatic lenet_pkg::opcode_e rand_op();
        int r;
        r = $unsigned($random(seed)) % 3;
        case (r)
            0:       return lenet_pkg::OP_CONV;
            1:       return lenet_pkg::OP_CONV_RELU;
            default: return lenet_pkg::OP_POOL_MAX;
        endcase
    endfunction

    function automatic lenet_pkg::window_cmd_t make_cmd(input lenet_pkg::opcode_e op,
                                                        input logic full);
        lenet_pkg::window_cmd_t cmd;
        cmd.op = op;
        for (int i = 0; i < lenet_pkg::WIN_N; i++) begin
            cmd.pix[i] = full ? any_word() : small_word();
            cmd.wgt[i] = full ? any_word() : small_word();
        end
        cmd.bias = full ? any_word() : small_word();
        return cmd;
    endfunction

    // one clock with inputs changed just after the edge
    task automatic step();
        @(posedge clk);
        #1;
        out_ready = ready_random ? (($random(seed) & 1) == 1) : 1'b1;
    endtask

    task automatic send_cmd(input lenet_pkg::window_cmd_t cmd);
        logic taken;
        taken    = 1'b0;
        in_cmd   = cmd;
        in_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            step();
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            step();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("results still outstanding 50 cycles after the last command");
            fail_count++;
        end
    endtask

    task automatic end_test(input string name, input int n_cmds);
        $display("test %-8s %0d commands, %0d errors", name, n_cmds,
                 fail_count - test_fail_base);
        test_fail_base = fail_count;
    endtask

    task automatic sat_case(input lenet_pkg::word_t p, input lenet_pkg::word_t w,
                            input lenet_pkg::word_t b, input lenet_pkg::word_t expected);
        lenet_pkg::window_cmd_t cmd;
        cmd.op   = lenet_pkg::OP_CONV;
        cmd.bias = b;
        for (int i = 0; i < lenet_pkg::WIN_N; i++) begin
            cmd.pix[i] = p;
            cmd.wgt[i] = w;
        end
        send_cmd(cmd);
        drain();
        if (last_out.value !== expected) begin
            $display("Fail out_data.value expected %h actual %h", expected, last_out.value);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard samples mid-cycle where everything is settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a result came out with no command outstanding");
                    fail_count++;
                end else begin
                    exp_res  = exp_q.pop_front();
                    last_out = out_data;
                    if (out_data.value !== exp_res.value) begin
                        $display("Fail out_data.value expected %h actual %h",
                                 exp_res.value, out_data.value);
                        fail_count++;
                    end else if (out_data.op !== exp_res.op) begin
                        $display("Fail out_data.op expected %h actual %h",
                                 exp_res.op, out_data.op);
                        fail_count++;
                    end else begin
                        pass_count++;
                    end
                end
            end
            if (in_valid && in_ready) exp_q.push_back(ref_window(in_cmd));  // accepted next edge
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        lenet_pkg::window_cmd_t cmd;
        int                     lat;
        seed           = 57049;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_cmd         = '0;
        out_ready      = 1'b1;
        ready_random   = 1'b0;
        pass_count     = 0;
        fail_count     = 0;
        test_fail_base = 0;
        last_out       = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset state and latency
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("Fail out_valid expected 0 actual %h", out_valid);
            fail_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail in_ready expected 1 actual %h", in_ready);
            fail_count++;
        end
        @(posedge clk);
        #1;
        in_cmd   = make_cmd(lenet_pkg::OP_CONV, 1'b0);
        in_valid = 1'b1;
        @(negedge clk);
        if (!in_ready) begin
            $display("the first command after reset was not accepted");
            fail_count++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!out_valid && lat < 10);
        if (lat != 3) begin
            $display("out_valid rose %0d cycles after the accepting edge instead of 3", lat);
            fail_count++;
        end
        step();
        drain();
        end_test("latency", 1);

        for (int i = 0; i < N_CONV; i++) send_cmd(make_cmd(lenet_pkg::OP_CONV, 1'b0));
        drain();
        end_test("conv", N_CONV);

        sat_case(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
        sat_case(16'h7FFF, 16'h8000, 16'h8000, 16'h8000);
        sat_case(16'h8000, 16'h8000, 16'h0000, 16'h7FFF);  // two negatives
        sat_case(16'h8000, 16'h7FFF, 16'h8000, 16'h8000);
        end_test("sat", N_SAT);

        for (int i = 0; i < N_RELU; i++) begin
            cmd = make_cmd(lenet_pkg::OP_CONV, 1'b0);
            if (i % 2 == 0) begin
                for (int k = 0; k < lenet_pkg::WIN_N; k++) begin
                    cmd.pix[k] = pos_word();
                    cmd.wgt[k] = neg_word();
                end
                cmd.bias = neg_word();  // sum strictly negative
            end
            send_cmd(cmd);
            cmd.op = lenet_pkg::OP_CONV_RELU;
            send_cmd(cmd);
            drain();
            if (i % 2 == 0 && last_out.value !== 16'h0000) begin
                $display("Fail out_data.value expected 0000 actual %h", last_out.value);
                fail_count++;
            end
        end
        end_test("relu", 2 * N_RELU);

        for (int i = 0; i < N_POOL; i++) begin
            cmd = make_cmd(lenet_pkg::OP_POOL_MAX, 1'b1);
            if (i % 2 == 0) begin
                for (int k = 0; k < lenet_pkg::WIN_N; k++) cmd.pix[k] = neg_word();
            end
            send_cmd(cmd);
        end
        drain();
        end_test("pool", N_POOL);

        // mixed stream under back-pressure
        ready_random = 1'b1;
        for (int i = 0; i < N_STREAM; i++) begin
            if (($random(seed) & 3) == 0) step();  // idle cycle on the input
            send_cmd(make_cmd(rand_op(), i % 2 == 0));
        end
        ready_random = 1'b0;
        drain();
        end_test("stream", N_STREAM);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            fail_count++;
        end
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
